/* include/fetch_consts.svh */
// fetch subsystem constants
`ifndef FETCH_CONSTS_SVH
`define FETCH_CONSTS_SVH

////////////////////////////////////////////////////////////
// fetch width
////////////////////////////////////////////////////////////

// instruction slots per fetched word
// slot split assumes two 32-bit slots in one 64-bit word
`define NUM_SUPER 2

// pc after reset
`define RESET_PC 64'h0

////////////////////////////////////////////////////////////
// storage depths
////////////////////////////////////////////////////////////

// branch target buffer entries, index is pc[4:2]
`define BTB_DEPTH 8

// memory depth in 64-bit words, word address is pc[10:3]
`define MEM_WORDS 256

`endif

/* rtl/fetch_pkg.sv */
// fetch path types
`include "fetch_consts.svh"

package fetch_pkg;

  // byte address, also the program counter
  typedef logic [63:0] addr_t;

  // one instruction slot
  typedef logic [31:0] inst_t;

  // one valid bit per slot
  typedef logic [`NUM_SUPER-1:0] slot_mask_t;

  // btb index, taken from pc bits above the instruction offset
  typedef logic [$clog2(`BTB_DEPTH)-1:0] btb_idx_t;

  // btb tag, the pc bits above the index
  typedef logic [63-$clog2(`BTB_DEPTH)-2:0] btb_tag_t;

endpackage

/* rtl/mem_pkg.sv */
// memory side types
`include "fetch_consts.svh"

package mem_pkg;

  // one memory word
  typedef logic [63:0] word_t;

  // word address into the unified memory
  typedef logic [$clog2(`MEM_WORDS)-1:0] waddr_t;

  // one write enable per byte lane
  typedef logic [7:0] bmask_t;

  // arbiter winner, also tags the response one cycle later
  typedef enum logic [1:0] {GRANT_NONE, GRANT_FETCH, GRANT_DATA} grant_t;

endpackage

/* rtl/fetch_stage.sv */
// two-wide instruction fetch
`include "fetch_consts.svh"

module fetch_stage (
  input  logic                              clock,
  input  logic                              reset,
  input  logic                              get_next_inst,
  input  logic                              fetch_grant,
  input  logic                              fetch_rvalid,
  input  mem_pkg::word_t                    rdata,
  input  fetch_pkg::addr_t                  next_pc,
  input  logic                              take,
  input  fetch_pkg::slot_mask_t             final_mask,
  output logic                              fetch_req,
  output fetch_pkg::addr_t                  fetch_addr,
  output fetch_pkg::addr_t                  pc,
  output fetch_pkg::slot_mask_t             raw_mask,
  output fetch_pkg::inst_t [`NUM_SUPER-1:0] if_inst,
  output fetch_pkg::addr_t [`NUM_SUPER-1:0] if_npc,
  output fetch_pkg::slot_mask_t             if_valid
);
  import fetch_pkg::*;

  // pc the outstanding grant was issued for
  addr_t granted_pc;
  addr_t aligned_pc;
  // high from the first cycle after reset
  logic  run_q;
  // response belongs to the current pc
  logic  fresh;

  ////////////////////////////////////////////////////////////
  // request side
  ////////////////////////////////////////////////////////////

  assign aligned_pc = {pc[63:3], 3'b000};
  assign fetch_req  = run_q;
  assign fetch_addr = aligned_pc;

  // pc moves on redirect even under stall, otherwise only on a fresh word
  always_ff @(posedge clock)
  begin
    if (reset)
    begin
      run_q <= 1'b0;
      pc    <= `RESET_PC;
    end
    else
    begin
      run_q <= 1'b1;
      if (take || (fresh && get_next_inst))
        pc <= next_pc;
    end
  end

  // remember which pc each grant fetched
  always_ff @(posedge clock)
  begin
    if (fetch_grant)
      granted_pc <= pc;
  end

  ////////////////////////////////////////////////////////////
  // response side
  ////////////////////////////////////////////////////////////

  // a word fetched for an older pc is dropped here
  assign fresh = fetch_rvalid && (granted_pc == pc);

  // slot 0 is skipped when pc points at the upper half
  assign raw_mask[0] = fresh && !pc[2];
  assign raw_mask[1] = fresh;

  // low half is slot 0
  always_comb
  begin
    for (int s = 0; s < `NUM_SUPER; s++)
      if_inst[s] = rdata[32*s +: 32];
  end

  // slot 0 npc is pc itself when slot 0 is not used
  assign if_npc[0] = pc[2] ? pc : (pc + 64'd4);
  assign if_npc[1] = aligned_pc + 64'd8;
  // branch squash comes back from the predictor
  assign if_valid  = final_mask;

endmodule

/* rtl/branch_predictor.sv */
// direct-mapped branch target buffer
`include "fetch_consts.svh"

module branch_predictor (
  input  logic                  clock,
  input  logic                  reset,
  input  fetch_pkg::addr_t      pc,
  input  fetch_pkg::slot_mask_t raw_mask,
  input  logic                  redirect,
  input  fetch_pkg::addr_t      redirect_pc,
  input  logic                  btb_wr,
  input  fetch_pkg::addr_t      btb_wr_pc,
  input  fetch_pkg::addr_t      btb_wr_target,
  output fetch_pkg::addr_t      next_pc,
  output logic                  take,
  output fetch_pkg::slot_mask_t final_mask
);
  import fetch_pkg::*;

  // entry storage
  logic     btb_valid [`BTB_DEPTH];
  btb_tag_t btb_tag [`BTB_DEPTH];
  addr_t    btb_target [`BTB_DEPTH];

  addr_t    slot_pc [`NUM_SUPER];
  logic     hit [`NUM_SUPER];

  function automatic btb_idx_t idx_of(input addr_t a);
    return a[$bits(btb_idx_t)+1:2];
  endfunction

  function automatic btb_tag_t tag_of(input addr_t a);
    return a[63:$bits(btb_idx_t)+2];
  endfunction

  ////////////////////////////////////////////////////////////
  // buffer update
  ////////////////////////////////////////////////////////////

  // new entry visible from the next clock
  always_ff @(posedge clock)
  begin
    if (reset)
    begin
      for (int e = 0; e < `BTB_DEPTH; e++)
        btb_valid[e] <= 1'b0;
    end
    else if (btb_wr)
      btb_valid[idx_of(btb_wr_pc)] <= 1'b1;
  end

  // tag and target of the written entry
  always_ff @(posedge clock)
  begin
    if (btb_wr)
    begin
      btb_tag[idx_of(btb_wr_pc)]    <= tag_of(btb_wr_pc);
      btb_target[idx_of(btb_wr_pc)] <= btb_wr_target;
    end
  end

  ////////////////////////////////////////////////////////////
  // lookup and next pc
  ////////////////////////////////////////////////////////////

  // both slots looked up in parallel
  always_comb
  begin
    for (int s = 0; s < `NUM_SUPER; s++)
    begin
      slot_pc[s] = {pc[63:3], 3'b000} + addr_t'(4 * s);
      hit[s]     = raw_mask[s] && btb_valid[idx_of(slot_pc[s])] &&
                   (btb_tag[idx_of(slot_pc[s])] == tag_of(slot_pc[s]));
    end
  end

  // redirect wins over everything, then the earlier slot
  always_comb
  begin
    if (redirect)
      next_pc = redirect_pc;
    else if (hit[0])
      next_pc = btb_target[idx_of(slot_pc[0])];
    else if (hit[1])
      next_pc = btb_target[idx_of(slot_pc[1])];
    else
      next_pc = slot_pc[0] + 64'd8;
  end

  assign take = redirect;

  // redirect kills the word in flight, a slot 0 hit kills slot 1
  assign final_mask[0] = raw_mask[0] && !redirect;
  assign final_mask[1] = raw_mask[1] && !redirect && !hit[0];

endmodule

/* rtl/mem_arbiter.sv */
// round-robin memory arbiter
module mem_arbiter (
  input  logic             clock,
  input  logic             reset,
  input  logic             fetch_req,
  input  fetch_pkg::addr_t fetch_addr,
  input  logic             data_req,
  input  mem_pkg::waddr_t  data_addr,
  input  logic             data_we,
  input  mem_pkg::word_t   data_wdata,
  input  mem_pkg::bmask_t  data_bmask,
  output logic             fetch_grant,
  output logic             data_grant,
  output logic             fetch_rvalid,
  output logic             data_rvalid,
  output logic             mem_en,
  output logic             mem_we,
  output mem_pkg::waddr_t  mem_addr,
  output mem_pkg::word_t   mem_wdata,
  output mem_pkg::bmask_t  mem_bmask
);
  import mem_pkg::*;

  grant_t win;
  // last winner, resets so that data goes first
  grant_t last_q;
  // routes the registered read one cycle after the grant
  grant_t route_q;

  // on contention the side that lost last time wins
  always_comb
  begin
    if (fetch_req && data_req)
      win = (last_q == GRANT_DATA) ? GRANT_FETCH : GRANT_DATA;
    else if (fetch_req)
      win = GRANT_FETCH;
    else if (data_req)
      win = GRANT_DATA;
    else
      win = GRANT_NONE;
  end

  always_ff @(posedge clock)
  begin
    if (reset)
    begin
      last_q  <= GRANT_FETCH;
      route_q <= GRANT_NONE;
    end
    else
    begin
      route_q <= win;
      if (win != GRANT_NONE)
        last_q <= win;
    end
  end

  assign fetch_grant  = (win == GRANT_FETCH);
  assign data_grant   = (win == GRANT_DATA);
  assign fetch_rvalid = (route_q == GRANT_FETCH);
  assign data_rvalid  = (route_q == GRANT_DATA);

  // memory port follows the winner
  assign mem_en    = (win != GRANT_NONE);
  assign mem_we    = data_grant && data_we;
  // fetch address is a byte address, drop the offset bits
  assign mem_addr  = data_grant ? data_addr : fetch_addr[$bits(waddr_t)+2:3];
  assign mem_wdata = data_wdata;
  assign mem_bmask = data_bmask;

endmodule

/* rtl/unified_mem.sv */
// unified single-port memory
`include "fetch_consts.svh"

module unified_mem (
  input  logic            clock,
  input  logic            mem_en,
  input  logic            mem_we,
  input  mem_pkg::waddr_t mem_addr,
  input  mem_pkg::word_t  mem_wdata,
  input  mem_pkg::bmask_t mem_bmask,
  output mem_pkg::word_t  mem_rdata
);
  import mem_pkg::*;

  // storage, one 64-bit word per entry
  word_t mem [`MEM_WORDS];

  ////////////////////////////////////////////////////////////
  // write port
  ////////////////////////////////////////////////////////////

  // only lanes with a set mask bit change
  always_ff @(posedge clock)
  begin
    if (mem_en && mem_we)
    begin
      for (int b = 0; b < $bits(bmask_t); b++)
      begin
        if (mem_bmask[b])
          mem[mem_addr][8*b +: 8] <= mem_wdata[8*b +: 8];
      end
    end
  end

  ////////////////////////////////////////////////////////////
  // read port
  ////////////////////////////////////////////////////////////

  // data out one cycle after the enable
  // a write cycle returns the word as it was before the write
  always_ff @(posedge clock)
  begin
    if (mem_en)
      mem_rdata <= mem[mem_addr];
  end

endmodule

/* rtl/data_port.sv */
// load and store request port
module data_port (
  input  logic             clock,
  input  logic             reset,
  input  logic             data_cmd,
  input  logic             data_cmd_we,
  input  fetch_pkg::addr_t data_cmd_addr,
  input  mem_pkg::word_t   data_cmd_wdata,
  input  mem_pkg::bmask_t  data_cmd_bmask,
  input  logic             data_grant,
  input  logic             data_rvalid,
  input  mem_pkg::word_t   rdata,
  output logic             data_req,
  output mem_pkg::waddr_t  data_addr,
  output logic             data_we,
  output mem_pkg::word_t   data_wdata,
  output mem_pkg::bmask_t  data_bmask,
  output logic             data_busy,
  output mem_pkg::word_t   load_data,
  output logic             load_valid
);
  import mem_pkg::*;

  logic   busy_q;
  // last granted access was a load
  logic   load_q;
  logic   accept;
  waddr_t addr_q;
  word_t  wdata_q;
  bmask_t bmask_q;
  logic   we_q;

  assign accept = data_cmd && !busy_q;

  // held until granted, freed the cycle after
  always_ff @(posedge clock)
  begin
    if (reset)
    begin
      busy_q <= 1'b0;
      load_q <= 1'b0;
    end
    else
    begin
      if (accept)
        busy_q <= 1'b1;
      else if (data_grant)
        busy_q <= 1'b0;
      if (data_grant)
        load_q <= !we_q;
    end
  end

  // command payload, byte address turned into a word address
  always_ff @(posedge clock)
  begin
    if (accept)
    begin
      we_q    <= data_cmd_we;
      addr_q  <= data_cmd_addr[$bits(waddr_t)+2:3];
      wdata_q <= data_cmd_wdata;
      bmask_q <= data_cmd_bmask;
    end
  end

  assign data_req   = busy_q;
  assign data_busy  = busy_q;
  assign data_addr  = addr_q;
  assign data_we    = we_q;
  assign data_wdata = wdata_q;
  assign data_bmask = bmask_q;

  // stores get a response strobe too, it is not reported
  assign load_valid = data_rvalid && load_q;
  assign load_data  = rdata;

endmodule

/* rtl/fetch_subsystem.sv */
// fetch subsystem top level
`include "fetch_consts.svh"

module fetch_subsystem (
  input  logic                              clock,
  input  logic                              reset,
  input  logic                              get_next_inst,
  input  logic                              redirect,
  input  fetch_pkg::addr_t                  redirect_pc,
  input  logic                              btb_wr,
  input  fetch_pkg::addr_t                  btb_wr_pc,
  input  fetch_pkg::addr_t                  btb_wr_target,
  input  logic                              data_cmd,
  input  logic                              data_cmd_we,
  input  fetch_pkg::addr_t                  data_cmd_addr,
  input  mem_pkg::word_t                    data_cmd_wdata,
  input  mem_pkg::bmask_t                   data_cmd_bmask,
  output logic                              data_busy,
  output mem_pkg::word_t                    load_data,
  output logic                              load_valid,
  output fetch_pkg::inst_t [`NUM_SUPER-1:0] if_inst,
  output fetch_pkg::addr_t [`NUM_SUPER-1:0] if_npc,
  output fetch_pkg::slot_mask_t             if_valid
);
  import fetch_pkg::*;
  import mem_pkg::*;

  ////////////////////////////////////////////////////////////
  // fetch to predictor
  ////////////////////////////////////////////////////////////

  addr_t      pc;
  addr_t      next_pc;
  slot_mask_t raw_mask;
  slot_mask_t final_mask;
  logic       take;

  ////////////////////////////////////////////////////////////
  // requesters to arbiter to memory
  ////////////////////////////////////////////////////////////

  logic       fetch_req;
  addr_t      fetch_addr;
  logic       fetch_grant;
  logic       fetch_rvalid;
  logic       data_req;
  waddr_t     data_addr;
  logic       data_we;
  word_t      data_wdata;
  bmask_t     data_bmask;
  logic       data_grant;
  logic       data_rvalid;
  logic       mem_en;
  logic       mem_we;
  waddr_t     mem_addr;
  word_t      mem_wdata;
  bmask_t     mem_bmask;
  // shared read data, routed by the rvalid strobes
  word_t      mem_rdata;

  // port names match the nets above
  fetch_stage i_fetch (.*, .rdata(mem_rdata));

  branch_predictor i_bp (.*);

  mem_arbiter i_arb (.*);

  unified_mem i_mem (.*);

  data_port i_data (.*, .rdata(mem_rdata));

endmodule

/* verif/fetch_asserts.sv */
// memory arbiter assertions
module fetch_asserts (
  input logic             clock,
  input logic             reset,
  input logic             fetch_req,
  input logic             data_req,
  input logic             fetch_grant,
  input logic             data_grant,
  input logic             fetch_rvalid,
  input logic             data_rvalid,
  input fetch_pkg::addr_t fetch_addr
);
  timeunit 1ns;
  timeprecision 100ps;

  ////////////////////////////////////////////////////////////
  // grants
  ////////////////////////////////////////////////////////////

  // one winner at most, and only a side that asked
  grant_legal: assert property (@(posedge clock) disable iff (reset)
    !(fetch_grant && data_grant) && (!fetch_grant || fetch_req) &&
    (!data_grant || data_req))
    else $error("illegal grant pattern");

  ////////////////////////////////////////////////////////////
  // responses
  ////////////////////////////////////////////////////////////

  // each strobe needs a grant in the cycle before
  fetch_resp_after_grant: assert property (@(posedge clock) disable iff (reset)
    fetch_rvalid |-> $past(fetch_grant))
    else $error("fetch response without a grant");

  data_resp_after_grant: assert property (@(posedge clock) disable iff (reset)
    data_rvalid |-> $past(data_grant))
    else $error("data response without a grant");

  // fetch always asks for a whole word
  fetch_aligned: assert property (@(posedge clock) disable iff (reset)
    fetch_addr[2:0] == 3'b000)
    else $error("fetch address not word aligned");

endmodule

/* verif/fetch_tb.sv */
// fetch subsystem testbench
`include "fetch_consts.svh"

module fetch_tb;
  timeunit 1ns;
  timeprecision 100ps;

  import fetch_pkg::*;
  import mem_pkg::*;

  // limit for one data port access in cycles
  localparam int TIMEOUT = 100;

  logic                   clock;
  logic                   reset;
  logic                   get_next_inst;
  logic                   redirect;
  addr_t                  redirect_pc;
  logic                   btb_wr;
  addr_t                  btb_wr_pc;
  addr_t                  btb_wr_target;
  logic                   data_cmd;
  logic                   data_cmd_we;
  addr_t                  data_cmd_addr;
  word_t                  data_cmd_wdata;
  bmask_t                 data_cmd_bmask;
  logic                   data_busy;
  word_t                  load_data;
  logic                   load_valid;
  inst_t [`NUM_SUPER-1:0] if_inst;
  addr_t [`NUM_SUPER-1:0] if_npc;
  slot_mask_t             if_valid;

  // memory and buffer models
  word_t       model_mem [`MEM_WORDS];
  logic        model_valid [`BTB_DEPTH];
  logic [58:0] model_tag [`BTB_DEPTH];
  addr_t       model_target [`BTB_DEPTH];

  // pc the next fresh word must belong to
  addr_t exp_pc;
  int    fetch_count;
  int    squash_count;
  int    upper_count;
  logic  check_en;
  // 0 held, 1 running, 2 random stalls
  int    stall_mode;

  fetch_subsystem i_dut (.*);

  bind mem_arbiter fetch_asserts i_asserts (
    .clock(clock),
    .reset(reset),
    .fetch_req(fetch_req),
    .data_req(data_req),
    .fetch_grant(fetch_grant),
    .data_grant(data_grant),
    .fetch_rvalid(fetch_rvalid),
    .data_rvalid(data_rvalid),
    .fetch_addr(fetch_addr)
  );

  initial clock = 1'b0;
  always #5 clock = ~clock;

  ////////////////////////////////////////////////////////////
  // reference
  ////////////////////////////////////////////////////////////

  function automatic logic btb_hit(input addr_t a);
    return model_valid[a[4:2]] && (model_tag[a[4:2]] == a[63:5]);
  endfunction

  // slots, npc values and next pc for one fresh word at pc
  function automatic addr_t predict(input addr_t pc, input logic redir, input addr_t rpc,
                                    output slot_mask_t mask, output addr_t npc0,
                                    output addr_t npc1);
    addr_t base;
    logic  hit0;
    logic  hit1;
    base    = {pc[63:3], 3'b000};
    hit0    = !pc[2] && btb_hit(base);
    hit1    = btb_hit(base + 64'd4);
    mask[0] = !redir && !pc[2];
    mask[1] = !redir && !hit0;
    npc0    = pc[2] ? pc : (pc + 64'd4);
    npc1    = base + 64'd8;
    if (redir)
      return rpc;
    else if (hit0)
      return model_target[base[2+:3]];
    else if (hit1)
      return model_target[pc[4:2] | 3'b001];
    else
      return base + 64'd8;
  endfunction

  task automatic expect_equal(input string what, input logic [63:0] got,
                              input logic [63:0] want);
    if (got !== want)
    begin
      $display("CHECK FAILED at %0t: %s is %h, expected %h", $time, what, got, want);
      $display("Checks failed");
      $fatal(1, "mismatch on %s", what);
    end
  endtask

  task automatic fail_timeout(input string what);
    $display("timeout while waiting for %s", what);
    $display("Checks failed");
    $fatal(1, "timeout");
  endtask

  ////////////////////////////////////////////////////////////
  // stimulus tasks
  ////////////////////////////////////////////////////////////

  // one load or store that returns once the port is free again
  task automatic data_access(input logic we, input int widx, input word_t wdata,
                             input bmask_t bmask);
    int    t;
    word_t merged;
    @(posedge clock);
    data_cmd       <= 1'b1;
    data_cmd_we    <= we;
    data_cmd_addr  <= addr_t'(widx) << 3;
    data_cmd_wdata <= wdata;
    data_cmd_bmask <= bmask;
    @(posedge clock);
    data_cmd <= 1'b0;
    @(negedge clock);
    expect_equal("data_busy", 64'(data_busy), 64'd1);
    t = 0;
    while (data_busy)
    begin
      @(negedge clock);
      t++;
      if (t > TIMEOUT)
        fail_timeout("data port grant");
    end
    if (we)
    begin
      // a store gives no load strobe in its response cycle
      expect_equal("load_valid", 64'(load_valid), 64'd0);
      // write landed on the edge that freed the port
      merged = model_mem[widx];
      for (int b = 0; b < 8; b++)
        if (bmask[b])
          merged[8*b +: 8] = wdata[8*b +: 8];
      model_mem[widx] = merged;
    end
    else
    begin
      t = 0;
      while (!load_valid)
      begin
        @(negedge clock);
        t++;
        if (t > TIMEOUT)
          fail_timeout("load data");
      end
      expect_equal("load_data", load_data, model_mem[widx]);
    end
  endtask

  task automatic write_btb(input addr_t bpc, input addr_t target);
    @(posedge clock);
    btb_wr        <= 1'b1;
    btb_wr_pc     <= bpc;
    btb_wr_target <= target;
    @(posedge clock);
    btb_wr <= 1'b0;
    // entry is live from this edge on
    model_valid[bpc[4:2]]  = 1'b1;
    model_tag[bpc[4:2]]    = bpc[63:5];
    model_target[bpc[4:2]] = target;
  endtask

  task automatic pulse_redirect(input addr_t target);
    @(posedge clock);
    redirect    <= 1'b1;
    redirect_pc <= target;
    @(posedge clock);
    redirect <= 1'b0;
  endtask

  task automatic wait_fetches(input int n);
    int start;
    int t;
    start = fetch_count;
    t = 0;
    while (fetch_count < start + n)
    begin
      @(posedge clock);
      t++;
      if (t > TIMEOUT + 20 * n)
        fail_timeout("instruction fetch");
    end
  endtask

  ////////////////////////////////////////////////////////////
  // stall driver and compare process
  ////////////////////////////////////////////////////////////

  always @(posedge clock)
  begin
    if (stall_mode == 2)
      get_next_inst <= ($urandom % 4) != 0;
    else
      get_next_inst <= (stall_mode == 1);
  end

  // outputs settle well before the falling edge
  always @(negedge clock)
  begin
    slot_mask_t mask;
    addr_t      npc0;
    addr_t      npc1;
    addr_t      nxt;
    word_t      fetched;
    if (reset)
      exp_pc = `RESET_PC;
    else
    begin
      nxt     = predict(exp_pc, redirect, redirect_pc, mask, npc0, npc1);
      fetched = model_mem[exp_pc[10:3]];
      if (check_en && (redirect || (if_valid != '0)))
      begin
        expect_equal("if_valid", 64'(if_valid), 64'(mask));
        if (mask != '0)
        begin
          expect_equal("if_npc[0]", if_npc[0], npc0);
          expect_equal("if_npc[1]", if_npc[1], npc1);
        end
        if (mask[0])
          expect_equal("if_inst[0]", 64'(if_inst[0]), 64'(fetched[31:0]));
        if (mask[1])
          expect_equal("if_inst[1]", 64'(if_inst[1]), 64'(fetched[63:32]));
      end
      if (if_valid != '0)
      begin
        fetch_count++;
        if (if_valid == 2'b01)
          squash_count++;
        if (if_valid == 2'b10)
          upper_count++;
      end
      // pc moves on redirect, or on a fresh word when not stalled
      if (redirect || ((if_valid != '0) && get_next_inst))
        exp_pc = nxt;
    end
  end

  ////////////////////////////////////////////////////////////
  // test sequence
  ////////////////////////////////////////////////////////////

  initial
  begin
    int idx;
    int start;
    void'($urandom(32'hbdb74ef7));
    reset          = 1'b1;
    get_next_inst  = 1'b0;
    redirect       = 1'b0;
    redirect_pc    = '0;
    btb_wr         = 1'b0;
    btb_wr_pc      = '0;
    btb_wr_target  = '0;
    data_cmd       = 1'b0;
    data_cmd_we    = 1'b0;
    data_cmd_addr  = '0;
    data_cmd_wdata = '0;
    data_cmd_bmask = '0;
    check_en       = 1'b0;
    stall_mode     = 0;
    fetch_count    = 0;
    squash_count   = 0;
    upper_count    = 0;
    for (int e = 0; e < `BTB_DEPTH; e++)
      model_valid[e] = 1'b0;
    repeat (16) @(posedge clock);
    reset <= 1'b0;

    // fill memory while fetch sits at the reset pc
    for (int i = 0; i < `MEM_WORDS; i++)
      data_access(1'b1, i, {$urandom(), $urandom()}, 8'hff);
    // masked stores each read back
    for (int i = 0; i < 24; i++)
    begin
      idx = $urandom % `MEM_WORDS;
      data_access(1'b1, idx, {$urandom(), $urandom()}, 8'($urandom));
      data_access(1'b0, idx, '0, '0);
    end

    // straight line fetch from the reset pc
    @(posedge clock);
    check_en   <= 1'b1;
    stall_mode <= 1;
    wait_fetches(16);
    expect_equal("squashed fetches", 64'(squash_count), 64'd0);

    // slot 0 hit to an upper-half target, then a slot 1 hit
    write_btb(64'h40, 64'h104);
    write_btb(64'h10c, 64'h200);
    pulse_redirect(64'h0);
    wait_fetches(16);
    expect_equal("slot 1 squashed", 64'(squash_count > 0), 64'd1);
    expect_equal("upper slot only", 64'(upper_count > 0), 64'd1);

    // held fetch repeats and a redirect still moves it
    @(posedge clock);
    stall_mode <= 0;
    wait_fetches(6);
    pulse_redirect(64'h300);
    wait_fetches(4);

    // data traffic mixed with stalling fetch
    @(posedge clock);
    stall_mode <= 2;
    for (int i = 0; i < 3; i++)
      write_btb(addr_t'(($urandom % 512) * 4), addr_t'(($urandom % 512) * 4));
    start = fetch_count;
    for (int i = 0; i < 30; i++)
      data_access(1'($urandom), $urandom % `MEM_WORDS, {$urandom(), $urandom()},
                  8'($urandom));
    expect_equal("fetch progress", 64'(fetch_count - start >= 10), 64'd1);
    wait_fetches(10);

    $display("All checks passed");
    $finish;
  end

endmodule

/* all.f */
+incdir+include
rtl/fetch_pkg.sv
rtl/mem_pkg.sv
rtl/fetch_stage.sv
rtl/branch_predictor.sv
rtl/mem_arbiter.sv
rtl/unified_mem.sv
rtl/data_port.sv
rtl/fetch_subsystem.sv
verif/fetch_asserts.sv
verif/fetch_tb.sv

/* run.sh */
#!/usr/bin/env bash
# build and run the fetch subsystem testbench with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert -f all.f --top-module fetch_tb -o fetch_sim

./obj_dir/fetch_sim
